// File: verilog/platform_cfg.svh
// Platform configuration macros
`ifndef PLATFORM_CFG_SVH
`define PLATFORM_CFG_SVH

// number of log entries, power of two
`define LOG_DEPTH 8

// button timestamp width
`define TIMESTAMP_W 16

// stable samples before a button level is taken
`define DEBOUNCE_CYCLES 16

// log entry payload width
`define PAYLOAD_W 16

`endif

// File: verilog/busPkg.sv
// Event log bus types
`include "platform_cfg.svh"

package busPkg;

    // ========================================================================
    // log entry source
    // ========================================================================

    // one bit is enough for the two writers
    typedef enum logic {
        srcUart   = 1'b0,
        srcButton = 1'b1
    } logSource_t;

    // ========================================================================
    // log entry
    // ========================================================================

    // 18 bits in all
    typedef struct packed {
        logSource_t             source;
        // set when an earlier event of this source was dropped
        logic                   lost;
        // narrower payloads are zero-extended
        logic [`PAYLOAD_W-1:0]  payload;
    } logEntry_t;

endpackage

// File: verilog/periphPkg.sv
// Peripheral event types
`include "platform_cfg.svh"

package periphPkg;

    // ========================================================================
    // uart receive event
    // ========================================================================

    // frameErr lands in payload bit 8, data in bits 7..0
    typedef struct packed {
        logic       frameErr;
        logic [7:0] data;
    } uartEvent_t;

    // ========================================================================
    // button press event
    // ========================================================================

    // free-running cycle count at the accepted press
    typedef struct packed {
        logic [`TIMESTAMP_W-1:0] stamp;
    } buttonEvent_t;

endpackage

// File: verilog/uartRx.sv
// UART 8N1 receiver
`timescale 1ns/100ps

module uartRx #(
    parameter int clksPerBit = 5
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  rxLine,
    output logic                  byteStrobe,
    output periphPkg::uartEvent_t eventData
);

    localparam int cntW = $clog2(clksPerBit + 1);
    // synchronizer and state entry eat two cycles of the start bit
    localparam logic [cntW-1:0] halfBit  = cntW'((clksPerBit - 1) / 2 - 1);
    localparam logic [cntW-1:0] lastTick = cntW'(clksPerBit - 1);

    typedef enum logic [1:0] {
        sIdle,
        sStart,
        sData,
        sStop
    } rxState_t;

    rxState_t        state;
    logic [1:0]      rxSync;
    logic            rxPrev;
    logic [cntW-1:0] tickCnt;
    logic [2:0]      bitIdx;
    logic [7:0]      shiftReg;
    logic            bitTick;

    // end of a full bit period
    assign bitTick = (tickCnt == lastTick);

    // ========================================================================
    // receive FSM
    // ========================================================================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // idle line is high
            rxSync     <= 2'b11;
            rxPrev     <= 1'b1;
            state      <= sIdle;
            tickCnt    <= '0;
            bitIdx     <= '0;
            byteStrobe <= 1'b0;
        end else begin
            rxSync     <= {rxSync[0], rxLine};
            rxPrev     <= rxSync[1];
            byteStrobe <= 1'b0;
            case (state)
                sIdle: begin
                    // falling start edge
                    if (rxPrev && !rxSync[1]) begin
                        state   <= sStart;
                        tickCnt <= '0;
                    end
                end
                sStart: begin
                    if (tickCnt == halfBit) begin
                        tickCnt <= '0;
                        bitIdx  <= '0;
                        // glitch if start bit is gone at mid-bit
                        state   <= rxSync[1] ? sIdle : sData;
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                sData: begin
                    if (bitTick) begin
                        tickCnt <= '0;
                        bitIdx  <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) begin
                            state <= sStop;
                        end
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                default: begin
                    // stop bit sampled here, strobe next cycle
                    if (bitTick) begin
                        tickCnt    <= '0;
                        state      <= sIdle;
                        byteStrobe <= 1'b1;
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ========================================================================
    // data path
    // ========================================================================

    always_ff @(posedge clk) begin
        // lsb first
        if (state == sData && bitTick) begin
            shiftReg <= {rxSync[1], shiftReg[7:1]};
        end
        if (state == sStop && bitTick) begin
            eventData.data     <= shiftReg;
            // low stop bit
            eventData.frameErr <= !rxSync[1];
        end
    end

    // one strobe per frame, frames are far longer than a cycle
    strobeSingle: assert property (@(posedge clk) disable iff (!arstN)
        byteStrobe |=> !byteStrobe);

endmodule

// File: verilog/buttonSync.sv
// Button debounce and press timestamp
`timescale 1ns/100ps
`include "platform_cfg.svh"

module buttonSync (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    button,
    output logic                    pressStrobe,
    output periphPkg::buttonEvent_t eventData
);

    localparam int dbW = $clog2(`DEBOUNCE_CYCLES + 1);
    localparam logic [dbW-1:0] dbLast = dbW'(`DEBOUNCE_CYCLES - 1);

    logic [1:0]              btnSync;
    logic                    stableLevel;
    logic                    prevLevel;
    logic [dbW-1:0]          stableCnt;
    logic [`TIMESTAMP_W-1:0] cycleCnt;

    // ========================================================================
    // sync, debounce, edge detect
    // ========================================================================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btnSync     <= '0;
            stableLevel <= 1'b0;
            prevLevel   <= 1'b0;
            stableCnt   <= '0;
            cycleCnt    <= '0;
            pressStrobe <= 1'b0;
        end else begin
            btnSync     <= {btnSync[0], button};
            // free-running stamp source
            cycleCnt    <= cycleCnt + 1'b1;
            prevLevel   <= stableLevel;
            // rising accepted level only
            pressStrobe <= stableLevel && !prevLevel;
            if (btnSync[1] == stableLevel) begin
                // bounce restarts the count
                stableCnt <= '0;
            end else if (stableCnt == dbLast) begin
                stableLevel <= btnSync[1];
                stableCnt   <= '0;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    // stamp lines up with the strobe
    always_ff @(posedge clk) begin
        if (stableLevel && !prevLevel) begin
            eventData.stamp <= cycleCnt;
        end
    end

endmodule

// File: verilog/eventWriter.sv
// Event to log request writer
`timescale 1ns/100ps
`include "platform_cfg.svh"

module eventWriter #(
    parameter type                eventT = logic [8:0],
    parameter busPkg::logSource_t source = busPkg::srcUart
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              strobe,
    input  eventT             eventData,
    input  logic              grant,
    output logic              request,
    output busPkg::logEntry_t entry
);

    localparam int payloadW = `PAYLOAD_W;

    logic [payloadW-1:0] heldPayload;
    logic                heldLost;
    logic                pendingLost;
    logic                capture;
    logic                drop;

    // slot is free when empty or leaving this cycle
    assign capture = strobe && (!request || grant);
    // still holding, new event has nowhere to go
    assign drop    = strobe && request && !grant;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            request     <= 1'b0;
            heldLost    <= 1'b0;
            pendingLost <= 1'b0;
        end else begin
            if (capture) begin
                request     <= 1'b1;
                // earlier drops ride on this entry
                heldLost    <= pendingLost;
                pendingLost <= 1'b0;
            end else if (grant) begin
                request <= 1'b0;
            end
            if (drop) begin
                pendingLost <= 1'b1;
            end
        end
    end

    // zero-extend into the payload field
    always_ff @(posedge clk) begin
        if (capture) begin
            heldPayload <= payloadW'(eventData);
        end
    end

    assign entry = '{source: source, lost: heldLost, payload: heldPayload};

    // arbiter only answers a raised request
    grantHasRequest: assert property (@(posedge clk) disable iff (!arstN)
        grant |-> request);

endmodule

// File: verilog/logArbiter.sv
// Round-robin log arbiter
`timescale 1ns/100ps

module logArbiter (
    input  logic              clk,
    input  logic              arstN,
    input  logic              requestUart,
    input  logic              requestButton,
    input  busPkg::logEntry_t entryUart,
    input  busPkg::logEntry_t entryButton,
    input  logic              full,
    output logic              grantUart,
    output logic              grantButton,
    output logic              push,
    output busPkg::logEntry_t pushEntry
);

    import busPkg::*;

    logSource_t lastServed;

    // grant in the request cycle, nothing while full
    always_comb begin
        grantUart   = 1'b0;
        grantButton = 1'b0;
        if (!full) begin
            if (requestUart && requestButton) begin
                // the one not served last wins
                grantButton = (lastServed == srcUart);
                grantUart   = (lastServed == srcButton);
            end else begin
                grantUart   = requestUart;
                grantButton = requestButton;
            end
        end
    end

    assign push      = grantUart || grantButton;
    assign pushEntry = grantButton ? entryButton : entryUart;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // uart wins the first tie
            lastServed <= srcButton;
        end else if (grantUart) begin
            lastServed <= srcUart;
        end else if (grantButton) begin
            lastServed <= srcButton;
        end
    end

    oneGrant: assert property (@(posedge clk) disable iff (!arstN)
        !(grantUart && grantButton));

endmodule

// File: verilog/eventLog.sv
// Circular event log
`timescale 1ns/100ps
`include "platform_cfg.svh"

module eventLog (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         push,
    input  busPkg::logEntry_t            pushEntry,
    input  logic                         popStrobe,
    output logic                         full,
    output busPkg::logEntry_t            headEntry,
    output logic [$clog2(`LOG_DEPTH):0]  logCount,
    output logic                         irq
);

    import busPkg::*;

    localparam int ptrW = $clog2(`LOG_DEPTH);
    localparam logic [ptrW:0] depth = (ptrW + 1)'(`LOG_DEPTH);

    logEntry_t       logMem [`LOG_DEPTH];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic            doPush;
    logic            doPop;

    // ========================================================================
    // status
    // ========================================================================

    assign full = (logCount == depth);
    // level, high while anything is logged
    assign irq  = (logCount != '0);

    assign doPush = push && !full;
    // pop on empty log ignored
    assign doPop  = popStrobe && irq;

    // ========================================================================
    // storage
    // ========================================================================

    always_ff @(posedge clk) begin
        if (doPush) begin
            logMem[wrPtr] <= pushEntry;
        end
    end

    // head visible the cycle after a push into an empty log
    assign headEntry = logMem[rdPtr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            logCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   logCount <= logCount + 1'b1;
                2'b01:   logCount <= logCount - 1'b1;
                default: logCount <= logCount;
            endcase
        end
    end

    // arbiter must hold off while full
    noPushFull: assert property (@(posedge clk) disable iff (!arstN)
        push |-> !full);

    // host pops only after irq
    noPopEmpty: assert property (@(posedge clk) disable iff (!arstN)
        popStrobe |-> irq);

endmodule

// File: verilog/fpgaPlatform.sv
// Peripheral event platform top
`timescale 1ns/100ps
`include "platform_cfg.svh"

module fpgaPlatform #(
    parameter int clksPerBit = 5
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        rxLine,
    input  logic                        button,
    input  logic                        popStrobe,
    output logic                        irq,
    output busPkg::logEntry_t           headEntry,
    output logic [$clog2(`LOG_DEPTH):0] logCount
);

    import busPkg::*;
    import periphPkg::*;

    logic         byteStrobe;
    logic         pressStrobe;
    uartEvent_t   uartEvent;
    buttonEvent_t buttonEvent;
    logic         requestUart;
    logic         requestButton;
    logic         grantUart;
    logic         grantButton;
    logic         push;
    logic         full;
    logEntry_t    entryUart;
    logEntry_t    entryButton;
    logEntry_t    pushEntry;

    // ========================================================================
    // event sources
    // ========================================================================

    uartRx #(.clksPerBit(clksPerBit)) uartRxInst (
        .clk(clk), .arstN(arstN), .rxLine(rxLine),
        .byteStrobe(byteStrobe), .eventData(uartEvent)
    );

    buttonSync buttonSyncInst (
        .clk(clk), .arstN(arstN), .button(button),
        .pressStrobe(pressStrobe), .eventData(buttonEvent)
    );

    // ========================================================================
    // writers, arbiter, log
    // ========================================================================

    eventWriter #(.eventT(uartEvent_t), .source(srcUart)) uartWriter (
        .clk(clk), .arstN(arstN), .strobe(byteStrobe), .eventData(uartEvent),
        .grant(grantUart), .request(requestUart), .entry(entryUart)
    );

    eventWriter #(.eventT(buttonEvent_t), .source(srcButton)) buttonWriter (
        .clk(clk), .arstN(arstN), .strobe(pressStrobe), .eventData(buttonEvent),
        .grant(grantButton), .request(requestButton), .entry(entryButton)
    );

    logArbiter arbiter (
        .clk(clk), .arstN(arstN),
        .requestUart(requestUart), .requestButton(requestButton),
        .entryUart(entryUart), .entryButton(entryButton), .full(full),
        .grantUart(grantUart), .grantButton(grantButton),
        .push(push), .pushEntry(pushEntry)
    );

    eventLog log (
        .clk(clk), .arstN(arstN), .push(push), .pushEntry(pushEntry),
        .popStrobe(popStrobe), .full(full), .headEntry(headEntry),
        .logCount(logCount), .irq(irq)
    );

endmodule

// File: test/tbPlatform.sv
// Event platform testbench
`timescale 1ns/100ps
`include "platform_cfg.svh"

module tbPlatform;

    import busPkg::*;

    localparam int clksPerBit = 5;
    localparam int cntW       = $clog2(`LOG_DEPTH) + 1;
    localparam int debounce   = `DEBOUNCE_CYCLES;

    logic            clk;
    logic            arstN;
    logic            rxLine;
    logic            button;
    logic            popStrobe;
    logic            irq;
    logEntry_t       headEntry;
    logic [cntW-1:0] logCount;

    // reference model and check enables
    logEntry_t                    expQ[$];
    logEntry_t                    expHead;
    logic [$bits(logEntry_t)-1:0] expMask;
    logic [cntW-1:0]              expCount;
    logic                         checkHead;
    logic                         checkCount;
    logic                         checkStamp;
    logic [`PAYLOAD_W-1:0]        prevStamp;
    logic [`PAYLOAD_W-1:0]        curStamp;
    logic [31:0]                  rngState;
    logic [7:0]                   rxByte;

    fpgaPlatform #(.clksPerBit(clksPerBit)) uut (
        .clk(clk), .arstN(arstN), .rxLine(rxLine), .button(button),
        .popStrobe(popStrobe), .irq(irq), .headEntry(headEntry), .logCount(logCount)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ========================================================================
    // helpers
    // ========================================================================

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] want,
                                  input logic [31:0] got);
        stopOnError($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, want, got));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // data in bits 7..0, frame error in bit 8, rest zero
    function automatic logEntry_t uartEntry(input logic [7:0] data, input logic frameErr,
                                            input logic lost);
        logEntry_t e;
        e.source  = srcUart;
        e.lost    = lost;
        e.payload = {{(`PAYLOAD_W - 9){1'b0}}, frameErr, data};
        return e;
    endfunction

    // stamp left open, masked in the head check
    function automatic logEntry_t buttonEntry();
        logEntry_t e;
        e.source  = srcButton;
        e.lost    = 1'b0;
        e.payload = '0;
        return e;
    endfunction

    // 8N1 frame, lsb first, then one idle bit
    task automatic sendFrame(input logic [7:0] data, input logic stopBit);
        int i;
        rxLine = 1'b0;
        repeat (clksPerBit) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxLine = data[i];
            repeat (clksPerBit) @(negedge clk);
        end
        rxLine = stopBit;
        repeat (clksPerBit) @(negedge clk);
        rxLine = 1'b1;
        repeat (clksPerBit) @(negedge clk);
    endtask

    task automatic waitIrq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            stopOnError("timeout: irq did not rise while an entry was expected");
        end
    endtask

    task automatic waitCount(input logic [cntW-1:0] target, input int limit);
        int n;
        n = 0;
        while (logCount != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (logCount != target) begin
            stopOnError("timeout: log count never reached the expected level");
        end
    endtask

    // count and irq checked for a window
    task automatic holdCount(input logic [cntW-1:0] value, input int cycles);
        expCount   = value;
        checkCount = 1'b1;
        repeat (cycles) @(negedge clk);
        checkCount = 1'b0;
    endtask

    // head compared at the same edge that pops it
    task automatic checkAndPop(input logEntry_t want);
        expHead    = want;
        // button stamps only have to rise
        expMask    = (want.source == srcButton) ? {2'b11, {`PAYLOAD_W{1'b0}}} : '1;
        checkStamp = (want.source == srcButton);
        curStamp   = headEntry.payload;
        checkHead  = 1'b1;
        popStrobe  = 1'b1;
        @(negedge clk);
        popStrobe  = 1'b0;
        checkHead  = 1'b0;
        if (checkStamp) begin
            prevStamp = curStamp;
        end
        checkStamp = 1'b0;
    endtask

    // ========================================================================
    // checks
    // ========================================================================

    headMatch: assert property (@(posedge clk) disable iff (!arstN)
        checkHead |-> ((headEntry ^ expHead) & expMask) == '0)
        else reportMismatch("headEntry", 32'($sampled(expHead)), 32'($sampled(headEntry)));

    countMatch: assert property (@(posedge clk) disable iff (!arstN)
        checkCount |-> logCount == expCount)
        else reportMismatch("logCount", 32'($sampled(expCount)), 32'($sampled(logCount)));

    // level follows occupancy
    irqMatch: assert property (@(posedge clk) disable iff (!arstN)
        checkCount |-> irq == (expCount != '0))
        else reportMismatch("irq", 32'($sampled(expCount != '0)), 32'($sampled(irq)));

    stampRising: assert property (@(posedge clk) disable iff (!arstN)
        checkStamp |-> headEntry.payload > prevStamp)
        else stopOnError($sformatf("FAIL t=%0t headEntry.payload expected above %h got %h",
            $time, $sampled(prevStamp), $sampled(headEntry.payload)));

    // ========================================================================
    // stimulus
    // ========================================================================

    initial begin
        int i;
        arstN      = 1'b0;
        rxLine     = 1'b1;
        button     = 1'b0;
        popStrobe  = 1'b0;
        checkHead  = 1'b0;
        checkCount = 1'b0;
        checkStamp = 1'b0;
        expHead    = '0;
        expMask    = '0;
        expCount   = '0;
        prevStamp  = '0;
        curStamp   = '0;
        rngState   = 32'h4610_5733;
        repeat (3) @(negedge clk);
        arstN = 1'b1;

        // empty log after reset
        holdCount(0, 4);

        // random bytes one at a time
        for (i = 0; i < 6; i++) begin
            rngState = xorshift(rngState);
            rxByte   = rngState[7:0];
            expQ.push_back(uartEntry(rxByte, 1'b0, 1'b0));
            sendFrame(rxByte, 1'b1);
            waitIrq(20 * clksPerBit);
            checkAndPop(expQ.pop_front());
        end

        // low stop bit
        expQ.push_back(uartEntry(8'hA5, 1'b1, 1'b0));
        sendFrame(8'hA5, 1'b0);
        waitIrq(20 * clksPerBit);
        checkAndPop(expQ.pop_front());

        // glitch shorter than the debounce window
        button = 1'b1;
        repeat (debounce - 6) @(negedge clk);
        button = 1'b0;
        holdCount(0, 2 * debounce + 8);

        // long presses, one entry each, release gives none
        for (i = 0; i < 3; i++) begin
            expQ.push_back(buttonEntry());
            button = 1'b1;
            waitIrq(debounce + 12);
            checkAndPop(expQ.pop_front());
            repeat (debounce) @(negedge clk);
            button = 1'b0;
            repeat (debounce + 8) @(negedge clk);
            holdCount(0, 4);
        end

        // overflow, log fills, one held in the writer, rest dropped
        for (i = 0; i < `LOG_DEPTH + 3; i++) begin
            rngState = xorshift(rngState);
            rxByte   = rngState[7:0];
            if (i <= `LOG_DEPTH) begin
                expQ.push_back(uartEntry(rxByte, 1'b0, 1'b0));
            end
            sendFrame(rxByte, 1'b1);
        end
        waitCount(cntW'(`LOG_DEPTH), 20 * clksPerBit);
        holdCount(cntW'(`LOG_DEPTH), 10);
        while (expQ.size() > 0) begin
            waitIrq(8);
            checkAndPop(expQ.pop_front());
        end
        holdCount(0, 4);

        // next byte carries the lost flag, the one after is clean
        for (i = 0; i < 2; i++) begin
            rngState = xorshift(rngState);
            rxByte   = rngState[7:0];
            expQ.push_back(uartEntry(rxByte, 1'b0, (i == 0)));
            sendFrame(rxByte, 1'b1);
            waitIrq(20 * clksPerBit);
            checkAndPop(expQ.pop_front());
        end

        // byte and press finishing together
        // uart was served last, so the button wins the tie
        rngState = xorshift(rngState);
        rxByte   = rngState[7:0];
        expQ.push_back(buttonEntry());
        expQ.push_back(uartEntry(rxByte, 1'b0, 1'b0));
        fork
            sendFrame(rxByte, 1'b1);
            begin
                // press strobe near the stop bit sample
                repeat (31) @(negedge clk);
                button = 1'b1;
                repeat (debounce + 8) @(negedge clk);
                button = 1'b0;
            end
        join
        waitCount(2, 40);
        holdCount(2, 3);
        checkAndPop(expQ.pop_front());
        waitIrq(4);
        checkAndPop(expQ.pop_front());
        holdCount(0, 4);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: fpgaPlatform.f
+incdir+verilog
verilog/busPkg.sv
verilog/periphPkg.sv
verilog/uartRx.sv
verilog/buttonSync.sv
verilog/eventWriter.sv
verilog/logArbiter.sv
verilog/eventLog.sv
verilog/fpgaPlatform.sv
test/tbPlatform.sv

// File: run.sh
#!/bin/sh
# compile and run the platform testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbPlatform \
    -f fpgaPlatform.f --Mdir obj_dir -o tbPlatform
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/tbPlatform 2>&1)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qxF '>>> PASS'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
